// File: Makefile
# Verilator build and run of the matrix stream transpose testbench

VERILATOR ?= verilator
TOP       ?= mst_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+design
design/mst_pkg.sv
design/tile_fifo.sv
design/tile_transpose_buffer.sv
design/mst_regs.sv
design/mst_top.sv
test/mst_checker.sv
test/mst_tb.sv

// File: design/mst_cfg.svh
/*
  Matrix stream transpose configuration
  Matrix, tile and element sizes plus the register map
*/
`default_nettype none

`ifndef MST_CFG_SVH
`define MST_CFG_SVH

// Matrix and tile geometry
`define MST_TOTAL_DIM 4
`define MST_COMPUTE_DIM 2
`define MST_DATA_WIDTH 8
`define MST_TILES_PER_SIDE (`MST_TOTAL_DIM / `MST_COMPUTE_DIM)

// Register map in word addresses
`define MST_ADDR_CTRL 4'd0
`define MST_ADDR_IN_COUNT 4'd1
`define MST_ADDR_OUT_COUNT 4'd2

`endif

`default_nettype wire

// File: design/mst_pkg.sv
/*
  Matrix stream transpose types
  Tile word with flat and element views, stream and Wishbone
  structs, control and status
*/
`include "mst_cfg.svh"
`default_nettype none

package mst_pkg;

  // One tile as stored flat in the FIFOs and decoded by row and column
  typedef union packed {
    logic [`MST_COMPUTE_DIM*`MST_COMPUTE_DIM*`MST_DATA_WIDTH-1:0] flat;
    logic [`MST_COMPUTE_DIM-1:0][`MST_COMPUTE_DIM-1:0][`MST_DATA_WIDTH-1:0] elem;
  } tile_t;

  typedef struct packed {
    tile_t tile;
    logic  valid;
  } tile_stream_t;

  // Wishbone classic
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic enable;
    logic clear;
  } mst_cfg_t;

  typedef struct packed {
    logic [15:0] in_count;
    logic [15:0] out_count;
  } mst_stat_t;

endpackage

`default_nettype wire

// File: design/mst_regs.sv
/*
  Matrix stream transpose registers
  Wishbone classic slave with CTRL (enable, self-clearing clear)
  and read-only matrix counts
*/
`timescale 1ns/100ps
`include "mst_cfg.svh"
`default_nettype none

module mst_regs
  import mst_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  wb_req_t   wb_req,
  output wb_rsp_t   wb_rsp,
  output mst_cfg_t  cfg,
  input  mst_stat_t stat
);

  logic        enable_q;
  logic        clear_q;
  logic        ack_q;
  logic [31:0] rd_dat_q;
  logic [31:0] rd_dat;
  logic        req;
  logic        ctrl_wr;

  // New request only while no ack is out
  assign req     = wb_req.cyc && wb_req.stb && !ack_q;
  assign ctrl_wr = req && wb_req.we && (wb_req.adr == `MST_ADDR_CTRL);

  always_comb begin
    case (wb_req.adr)
      // Clear bit reads back as zero
      `MST_ADDR_CTRL:      rd_dat = {30'b0, 1'b0, enable_q};
      `MST_ADDR_IN_COUNT:  rd_dat = {16'b0, stat.in_count};
      `MST_ADDR_OUT_COUNT: rd_dat = {16'b0, stat.out_count};
      default:             rd_dat = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q    <= 1'b0;
      enable_q <= 1'b1;
      clear_q  <= 1'b0;
    end else begin
      ack_q   <= req;
      clear_q <= ctrl_wr && wb_req.dat[1];
      if (ctrl_wr) begin
        enable_q <= wb_req.dat[0];
      end
    end
  end

  // Read data lands together with ack
  always_ff @(posedge clk) begin
    if (req && !wb_req.we) begin
      rd_dat_q <= rd_dat;
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: rd_dat_q};
  assign cfg    = '{enable: enable_q, clear: clear_q};

endmodule

`default_nettype wire

// File: design/mst_top.sv
/*
  Matrix stream transpose top
  Tile transpose buffer steered by a Wishbone register block
*/
`timescale 1ns/100ps
`default_nettype none

module mst_top
  import mst_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  tile_stream_t in,
  output logic         in_ready,
  output tile_stream_t out,
  input  logic         out_ready,
  input  wb_req_t      wb_req,
  output wb_rsp_t      wb_rsp
);

  mst_cfg_t  cfg;
  mst_stat_t stat;

  mst_regs u_regs (
    .clk   (clk),
    .rst   (rst),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp),
    .cfg   (cfg),
    .stat  (stat)
  );

  tile_transpose_buffer u_buffer (
    .clk      (clk),
    .rst      (rst),
    .cfg      (cfg),
    .in       (in),
    .in_ready (in_ready),
    .out      (out),
    .out_ready(out_ready),
    .stat     (stat)
  );

endmodule

`default_nettype wire

// File: design/tile_fifo.sv
/*
  Tile FIFO
  Circular buffer of tile words, one tile column deep,
  valid/ready on both sides and a synchronous flush
*/
`timescale 1ns/100ps
`include "mst_cfg.svh"
`default_nettype none

module tile_fifo
  import mst_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  clear,
  input  tile_t in_tile,
  input  logic  in_valid,
  output logic  in_ready,
  output tile_t out_tile,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int DEPTH = `MST_TILES_PER_SIDE;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  tile_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_tile  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_tile;
    end
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

`default_nettype wire

// File: design/tile_transpose_buffer.sv
/*
  Tile transpose buffer
  Steers incoming tiles into one FIFO per tile column, then drains
  the FIFOs one at a time so tiles leave in transposed order, with
  the elements of each tile transposed on the way out
*/
`timescale 1ns/100ps
`include "mst_cfg.svh"
`default_nettype none

module tile_transpose_buffer
  import mst_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  mst_cfg_t     cfg,
  input  tile_stream_t in,
  output logic         in_ready,
  output tile_stream_t out,
  input  logic         out_ready,
  output mst_stat_t    stat
);

  localparam int TPS = `MST_TILES_PER_SIDE;
  localparam int CD  = `MST_COMPUTE_DIM;
  localparam int CW  = (TPS > 1) ? $clog2(TPS) : 1;
  localparam logic [CW-1:0] LAST = CW'(TPS - 1);

  logic [CW-1:0]  wr_row;
  logic [CW-1:0]  wr_col;
  logic [CW-1:0]  rd_row;
  logic [CW-1:0]  rd_col;
  logic           run;
  logic           in_fire;
  logic           out_fire;
  logic           out_valid;
  logic [TPS-1:0] fifo_in_valid;
  logic [TPS-1:0] fifo_in_ready;
  logic [TPS-1:0] fifo_out_valid;
  logic [TPS-1:0] fifo_out_ready;
  tile_t          fifo_out_tile [TPS];
  tile_t          sel_tile;
  tile_t          xpose_tile;
  logic [15:0]    in_count;
  logic [15:0]    out_count;

  // Both stream sides stall while disabled or flushing
  assign run = cfg.enable && !cfg.clear;

  for (genvar i = 0; i < TPS; i++) begin : g_col_fifo
    // Write goes to the current tile column and read comes from the output row
    assign fifo_in_valid[i]  = run && in.valid && (wr_col == CW'(i));
    assign fifo_out_ready[i] = run && out_ready && (rd_row == CW'(i));

    tile_fifo u_fifo (
      .clk      (clk),
      .rst      (rst),
      .clear    (cfg.clear),
      .in_tile  (in.tile),
      .in_valid (fifo_in_valid[i]),
      .in_ready (fifo_in_ready[i]),
      .out_tile (fifo_out_tile[i]),
      .out_valid(fifo_out_valid[i]),
      .out_ready(fifo_out_ready[i])
    );
  end

  assign in_ready  = run && fifo_in_ready[wr_col];
  assign in_fire   = in.valid && in_ready;

  assign sel_tile  = fifo_out_tile[rd_row];
  assign out_valid = run && fifo_out_valid[rd_row];
  assign out_fire  = out_valid && out_ready;

  // Swap rows and columns inside the tile
  always_comb begin
    for (int r = 0; r < CD; r++) begin
      for (int c = 0; c < CD; c++) begin
        xpose_tile.elem[r][c] = sel_tile.elem[c][r];
      end
    end
  end

  assign out = '{tile: xpose_tile, valid: out_valid};

  // Input tile position in row-major order over the matrix
  always_ff @(posedge clk) begin
    if (rst || cfg.clear) begin
      wr_row <= '0;
      wr_col <= '0;
    end else if (in_fire) begin
      if (wr_col == LAST) begin
        wr_col <= '0;
        wr_row <= (wr_row == LAST) ? '0 : wr_row + 1'b1;
      end else begin
        wr_col <= wr_col + 1'b1;
      end
    end
  end

  // rd_row picks the output FIFO and rd_col walks its entries
  always_ff @(posedge clk) begin
    if (rst || cfg.clear) begin
      rd_row <= '0;
      rd_col <= '0;
    end else if (out_fire) begin
      if (rd_col == LAST) begin
        rd_col <= '0;
        rd_row <= (rd_row == LAST) ? '0 : rd_row + 1'b1;
      end else begin
        rd_col <= rd_col + 1'b1;
      end
    end
  end

  // Counted per whole matrix so a flushed partial never counts
  always_ff @(posedge clk) begin
    if (rst) begin
      in_count  <= '0;
      out_count <= '0;
    end else begin
      if (in_fire && wr_row == LAST && wr_col == LAST) begin
        in_count <= in_count + 1'b1;
      end
      if (out_fire && rd_row == LAST && rd_col == LAST) begin
        out_count <= out_count + 1'b1;
      end
    end
  end

  assign stat = '{in_count: in_count, out_count: out_count};

endmodule

`default_nettype wire

// File: test/mst_cases.txt
// Columns: tag, 16 input elements in row-major order, 16 expected output elements
// Output stream is tile by tile, each tile row by row, all values hex bytes

// Counting patterns
01 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 00 04 01 05 08 0c 09 0d 02 06 03 07 0a 0e 0b 0f
02 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 10 14 11 15 18 1c 19 1d 12 16 13 17 1a 1e 1b 1f
03 ff fe fd fc fb fa f9 f8 f7 f6 f5 f4 f3 f2 f1 f0 ff fb fe fa f7 f3 f6 f2 fd f9 fc f8 f5 f1 f4 f0
04 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff 00 44 11 55 88 cc 99 dd 22 66 33 77 aa ee bb ff

// Scattered values
05 a5 3c 7e 01 9b 42 d0 6f 18 e7 55 c3 2a 80 fe 64 a5 9b 3c 42 18 2a e7 80 7e d0 01 6f 55 fe c3 64
06 5a c1 0f 77 3e b2 49 d8 61 9c e0 14 8f 26 fb 03 5a 3e c1 b2 61 8f 9c 26 0f 49 77 d8 e0 fb 14 03

// File: test/mst_checker.sv
/*
  Matrix stream transpose checker
  Stream stability, single-cycle Wishbone ack and reset state
*/
`timescale 1ns/100ps
`default_nettype none

module mst_checker
  import mst_pkg::*;
(
  input logic         clk,
  input logic         rst,
  input mst_cfg_t     cfg,
  input tile_stream_t in,
  input logic         in_ready,
  input tile_stream_t out,
  input logic         out_ready,
  input wb_req_t      wb_req,
  input wb_rsp_t      wb_rsp
);

  int   assert_fails = 0;
  logic run;

  // Disable and clear may withdraw out.valid
  assign run = cfg.enable && !cfg.clear;

  a_in_stable: assert property (@(posedge clk) disable iff (rst)
    $past(in.valid && !in_ready) |-> (in.valid && $stable(in.tile)))
    else begin
      assert_fails++;
      $error("in tile changed or dropped while waiting");
    end

  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    ($past(out.valid && !out_ready) && run) |-> (out.valid && $stable(out.tile)))
    else begin
      assert_fails++;
      $error("out tile changed or dropped while waiting");
    end

  // A new request gets ack on the next cycle, for that cycle only
  a_ack_single: assert property (@(posedge clk) disable iff (rst)
    $rose(wb_req.cyc && wb_req.stb) |=> (wb_rsp.ack ##1 !wb_rsp.ack))
    else begin
      assert_fails++;
      $error("Wishbone ack late or held for two cycles");
    end

  a_reset_idle: assert property (@(posedge clk)
    rst |=> (!out.valid && !wb_rsp.ack))
    else begin
      assert_fails++;
      $error("out.valid or ack high right after reset");
    end

endmodule

bind mst_top mst_checker u_checker (
  .clk      (clk),
  .rst      (rst),
  .cfg      (cfg),
  .in       (in),
  .in_ready (in_ready),
  .out      (out),
  .out_ready(out_ready),
  .wb_req   (wb_req),
  .wb_rsp   (wb_rsp)
);

`default_nettype wire

// File: test/mst_tb.sv
/*
  Matrix stream transpose testbench
  Streams the case matrices through the DUT, steers it over Wishbone
  and compares the output tiles and matrix counts with the case file
*/
`timescale 1ns/100ps
`include "mst_cfg.svh"
`default_nettype none

module mst_tb
  import mst_pkg::*;
();

  localparam int TD              = `MST_TOTAL_DIM;
  localparam int CD              = `MST_COMPUTE_DIM;
  localparam int TPS             = `MST_TILES_PER_SIDE;
  localparam int TILES           = TPS * TPS;
  localparam int NUM_CASES       = 6;
  localparam int CASE_WORDS      = 1 + 2 * TD * TD;
  localparam int CLK_PERIOD      = 8;
  localparam int DRIVE_DELAY     = 1;
  localparam int WATCHDOG_CYCLES = 200 * NUM_CASES + 500;

  logic         clk;
  logic         rst;
  tile_stream_t in_s;
  logic         in_ready;
  tile_stream_t out_s;
  logic         out_ready;
  wb_req_t      wb_req;
  wb_rsp_t      wb_rsp;

  // Tag, input matrix and expected output stream per case
  logic [`MST_DATA_WIDTH-1:0] case_mem [NUM_CASES * CASE_WORDS];
  integer seed          = 32'h470d;
  int     error_count   = 0;
  int     checks_done   = 0;
  int     tests_done    = 0;
  int     matrices_sent = 0;

  mst_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .in       (in_s),
    .in_ready (in_ready),
    .out      (out_s),
    .out_ready(out_ready),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

  // Input tile (tr, tc) cut from the row-major case matrix
  function automatic tile_t input_tile(input int ci, input int tr, input int tc);
    tile_t t;
    for (int r = 0; r < CD; r++) begin
      for (int c = 0; c < CD; c++) begin
        t.elem[r][c] = case_mem[ci * CASE_WORDS + 1 + (tr * CD + r) * TD + tc * CD + c];
      end
    end
    return t;
  endfunction

  // Expected output tile k with its elements listed row by row
  function automatic tile_t expected_tile(input int ci, input int k);
    tile_t t;
    for (int i = 0; i < CD * CD; i++) begin
      t.elem[i / CD][i % CD] = case_mem[ci * CASE_WORDS + 1 + TD * TD + k * CD * CD + i];
    end
    return t;
  endfunction

  task automatic check_tile(input tile_t got, input tile_t exp, input string what);
    checks_done++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR @%0t: %s got %h expected %h", $time, what, got.flat, exp.flat);
    end
  endtask

  task automatic check_count(input mst_stat_t got, input mst_stat_t exp, input string what);
    checks_done++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR @%0t: %s in %0d out %0d, expected in %0d out %0d", $time, what,
               got.in_count, got.out_count, exp.in_count, exp.out_count);
    end
  endtask

  // One classic cycle that returns at the drive point after ack
  task automatic wb_cycle(input logic we, input logic [3:0] adr,
                          input logic [31:0] wdat, output logic [31:0] rdat);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    do @(negedge clk); while (!wb_rsp.ack);
    rdat = wb_rsp.dat;
    @(posedge clk);
    #DRIVE_DELAY;
    wb_req = '0;
  endtask

  task automatic verify_counts(input string what);
    logic [31:0] rdat;
    mst_stat_t   got;
    mst_stat_t   exp;
    wb_cycle(1'b0, `MST_ADDR_IN_COUNT, 32'h0, rdat);
    got.in_count = rdat[15:0];
    wb_cycle(1'b0, `MST_ADDR_OUT_COUNT, 32'h0, rdat);
    got.out_count = rdat[15:0];
    exp.in_count  = 16'(matrices_sent);
    exp.out_count = 16'(matrices_sent);
    check_count(got, exp, what);
  endtask

  // Tiles in row-major order with valid held until each transfer
  task automatic send_tiles(input int ci, input int count);
    for (int k = 0; k < count; k++) begin
      in_s = '{tile: input_tile(ci, k / TPS, k % TPS), valid: 1'b1};
      do @(negedge clk); while (!in_ready);
      @(posedge clk);
      #DRIVE_DELAY;
    end
    in_s.valid = 1'b0;
  endtask

  task automatic receive_tiles(input int ci, input bit stall);
    int rnd;
    bit taken;
    for (int k = 0; k < TILES; k++) begin
      taken = 1'b0;
      while (!taken) begin
        if (stall) begin
          rnd       = $random(seed);
          out_ready = rnd[0];
        end else begin
          out_ready = 1'b1;
        end
        @(negedge clk);
        if (out_s.valid && out_ready) begin
          check_tile(out_s.tile, expected_tile(ci, k),
                     $sformatf("case %0h tile %0d", case_mem[ci * CASE_WORDS], k));
          taken = 1'b1;
        end
        @(posedge clk);
        #DRIVE_DELAY;
      end
    end
    out_ready = 1'b0;
  endtask

  // A leftover tile means one was repeated or came from a flushed matrix
  task automatic expect_idle();
    @(negedge clk);
    checks_done++;
    if (out_s.valid) begin
      error_count++;
      $display("ERROR @%0t: extra tile waiting after the last expected one", $time);
    end
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // Next matrix enters while the previous one drains
  task automatic stream_cases(input bit stall);
    fork
      for (int ci = 0; ci < NUM_CASES; ci++) begin
        send_tiles(ci, TILES);
      end
      for (int ci = 0; ci < NUM_CASES; ci++) begin
        receive_tiles(ci, stall);
      end
    join
    matrices_sent += NUM_CASES;
    expect_idle();
  endtask

  task automatic stall_while_disabled(input int ci);
    logic [31:0] rdat;
    wb_cycle(1'b1, `MST_ADDR_CTRL, 32'h0, rdat);
    fork
      send_tiles(ci, TILES);
      receive_tiles(ci, 1'b0);
      begin
        repeat (20) begin
          @(negedge clk);
          checks_done++;
          if (in_ready || out_s.valid) begin
            error_count++;
            $display("ERROR @%0t: stream handshake active while disabled", $time);
          end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        wb_cycle(1'b1, `MST_ADDR_CTRL, 32'h1, rdat);
      end
    join
    matrices_sent++;
    expect_idle();
  endtask

  task automatic clear_partial(input int part_ci, input int full_ci);
    logic [31:0] rdat;
    out_ready = 1'b0;
    send_tiles(part_ci, TILES / 2);
    // Enable stays set while clear pulses
    wb_cycle(1'b1, `MST_ADDR_CTRL, 32'h3, rdat);
    fork
      send_tiles(full_ci, TILES);
      receive_tiles(full_ci, 1'b0);
    join
    matrices_sent++;
    expect_idle();
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_done++;
    if (error_count == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, error_count - errors_before);
    end
  endtask

  initial begin
    int errors_before;
    in_s      = '0;
    out_ready = 1'b0;
    wb_req    = '0;
    rst       = 1'b1;
    $readmemh("test/mst_cases.txt", case_mem);
    repeat (10) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    errors_before = error_count;
    stream_cases(1'b0);
    report_test("1 all cases, out_ready high", errors_before);

    errors_before = error_count;
    stream_cases(1'b1);
    report_test("2 all cases, random out_ready stalls", errors_before);

    errors_before = error_count;
    stall_while_disabled(0);
    report_test("3 stall while disabled", errors_before);

    errors_before = error_count;
    verify_counts("counts after all cases");
    report_test("4 matrix counts", errors_before);

    errors_before = error_count;
    clear_partial(4, 5);
    verify_counts("counts after clear");
    report_test("5 clear of a partial matrix", errors_before);

    if (u_dut.u_checker.assert_fails != 0) begin
      $display("Checker assertions failed %0d times", u_dut.u_checker.assert_fails);
    end
    error_count += u_dut.u_checker.assert_fails;
    $display("tests %0d, checks %0d, errors %0d", tests_done, checks_done, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
